// File: common/zx_config.svh
// Bus, RAM address and DAC widths, fixed banks and paging register bit positions
`ifndef ZX_CONFIG_SVH
`define ZX_CONFIG_SVH

// ======================================================================
// Bus and memory widths
// ======================================================================

`define ZX_ADDR_W 16
`define ZX_DATA_W 8

// Bit 17 selects ROM space, bits 16..14 bank, bits 13..0 offset
`define ZX_RAM_ADDR_W 18

// Beeper DAC input width
`define ZX_DAC_W 9

// ======================================================================
// Banks and port register bits
// ======================================================================

// Fixed banks at 4000 and 8000 in normal mode
`define ZX_SCREEN_BANK 3'd5
`define ZX_MID_BANK 3'd2

// 7FFD bits
`define ZX_PAGE_SCREEN_BIT 3
`define ZX_PAGE_ROM_BIT 4
`define ZX_PAGE_LOCK_BIT 5

// 1FFD bits
`define ZX_P3_SPECIAL_BIT 0
`define ZX_P3_ROM_BIT 2

`endif

// File: common/zx_pkg.sv
// Shared types: CPU address and data, RAM address, bank, machine model, DAC level
`include "zx_config.svh"

package zx_pkg;

	// CPU side
	typedef logic [`ZX_ADDR_W-1:0] zx_addr_t;
	typedef logic [`ZX_DATA_W-1:0] zx_data_t;

	// RAM side, ROM flag plus bank plus 16K offset
	typedef logic [`ZX_RAM_ADDR_W-1:0] zx_ram_addr_t;
	typedef logic [2:0] zx_bank_t;

	// Machine model, selected at reset
	typedef enum logic [1:0] {
		MODEL_128 = 2'd0,
		MODEL_48 = 2'd1,
		MODEL_PLUS3 = 2'd2
	} zx_model_t;

	// Beeper mix level
	typedef logic [`ZX_DAC_W-1:0] zx_level_t;

endpackage

// File: common/zx_bus_if.sv
// Internal CPU bus interface with strobe, pager, ULA and read mux modports
`timescale 1ns/1ps

interface zx_bus_if;
	import zx_pkg::*;

	zx_addr_t addr;
	zx_data_t cpu_dout;

	// Decoded active-high strobes
	logic io_wr_pulse;
	logic io_rd;
	logic mem_rd;
	logic mem_wr;

	modport strobe (
		output addr,
		output cpu_dout,
		output io_wr_pulse,
		output io_rd,
		output mem_rd,
		output mem_wr
	);

	modport pager (
		input addr,
		input cpu_dout,
		input io_wr_pulse,
		input mem_rd,
		input mem_wr
	);

	modport ula (
		input addr,
		input cpu_dout,
		input io_wr_pulse
	);

	modport mux (
		input addr,
		input io_rd
	);

endinterface

// File: source/zx_bus_strobe.sv
// Z80 strobe decoder with edge-detected I/O write pulse
`timescale 1ns/1ps

module zx_bus_strobe (
	input logic clk_sys,
	input logic reset,
	input zx_pkg::zx_addr_t addr,
	input zx_pkg::zx_data_t cpu_dout,
	input logic m1_n,
	input logic mreq_n,
	input logic iorq_n,
	input logic rd_n,
	input logic wr_n,
	zx_bus_if.strobe bus
);

	logic io_wr;
	logic io_wr_q;

	// Interrupt acknowledge has iorq low with m1 low, keep it out
	assign io_wr = ~iorq_n & ~wr_n & m1_n;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	assign bus.addr = addr;
	assign bus.cpu_dout = cpu_dout;

	// Memory strobes follow the CPU directly
	assign bus.mem_rd = ~mreq_n & ~rd_n;
	assign bus.mem_wr = ~mreq_n & ~wr_n;

	assign bus.io_rd = ~iorq_n & ~rd_n & m1_n;

	// One pulse per OUT, up to the first edge that sees it
	assign bus.io_wr_pulse = io_wr & ~io_wr_q;

endmodule

// File: memory_pager/zx_memory_pager.sv
// Memory pager: 7FFD and 1FFD registers, model latch, RAM address map, RAM enables
`timescale 1ns/1ps
`include "zx_config.svh"

module zx_memory_pager (
	input logic clk_sys,
	input logic reset,
	input zx_pkg::zx_model_t model,
	zx_bus_if.pager bus,
	output zx_pkg::zx_ram_addr_t ram_addr,
	output logic ram_we,
	output logic ram_rd,
	output logic screen_page
);
	import zx_pkg::*;

	zx_model_t model_q;
	zx_data_t page_reg;
	zx_data_t page_reg_plus3;

	logic is_48;
	logic is_plus3;
	logic page_disable;
	logic page_write;
	logic page_write_plus3;
	logic page_special;
	logic rom_space;
	logic [1:0] rom_sel;
	zx_bank_t top_bank;
	zx_bank_t special_bank;

	assign is_48 = (model_q == MODEL_48);
	assign is_plus3 = (model_q == MODEL_PLUS3);

	// Lock bit stays set until the next reset
	assign page_disable = is_48 | page_reg[`ZX_PAGE_LOCK_BIT];

	// 7FFD, partial decode; +3 also needs A14 high
	assign page_write = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~is_plus3)
		& ~page_disable;

	// 1FFD, +3 only
	assign page_write_plus3 = ~bus.addr[15] & ~bus.addr[14] & ~bus.addr[13]
		& bus.addr[12] & ~bus.addr[1] & is_plus3 & ~page_disable;

	// ======================================================================
	// Paging registers
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model;
			page_reg <= '0;
			page_reg_plus3 <= '0;
		end else if (bus.io_wr_pulse) begin
			if (page_write) begin
				page_reg <= bus.cpu_dout;
			end else if (page_write_plus3) begin
				page_reg_plus3 <= bus.cpu_dout;
			end
		end
	end

	// ======================================================================
	// Address mapping
	// ======================================================================

	assign page_special = page_reg_plus3[`ZX_P3_SPECIAL_BIT];
	assign top_bank = is_48 ? 3'd0 : page_reg[2:0];

	always_comb begin
		case (model_q)
			MODEL_48: rom_sel = 2'b01;
			MODEL_PLUS3: rom_sel = {page_reg_plus3[`ZX_P3_ROM_BIT], page_reg[`ZX_PAGE_ROM_BIT]};
			default: rom_sel = {1'b0, page_reg[`ZX_PAGE_ROM_BIT]};
		endcase
	end

	// All-RAM configurations of the +3
	always_comb begin
		case (page_reg_plus3[2:1])
			2'b00: special_bank = {1'b0, bus.addr[15:14]};
			2'b01: special_bank = {1'b1, bus.addr[15:14]};
			2'b10: special_bank = (bus.addr[15:14] == 2'b11) ? 3'd3 : {1'b1, bus.addr[15:14]};
			default: begin
				case (bus.addr[15:14])
					2'b00: special_bank = 3'd4;
					2'b01: special_bank = 3'd7;
					2'b10: special_bank = 3'd6;
					default: special_bank = 3'd3;
				endcase
			end
		endcase
	end

	always_comb begin
		if (page_special) begin
			ram_addr = {1'b0, special_bank, bus.addr[13:0]};
		end else begin
			case (bus.addr[15:14])
				2'b00: ram_addr = {2'b10, rom_sel, bus.addr[13:0]};
				2'b01: ram_addr = {1'b0, `ZX_SCREEN_BANK, bus.addr[13:0]};
				2'b10: ram_addr = {1'b0, `ZX_MID_BANK, bus.addr[13:0]};
				default: ram_addr = {1'b0, top_bank, bus.addr[13:0]};
			endcase
		end
	end

	// ROM is write protected
	assign rom_space = ~page_special & (bus.addr[15:14] == 2'b00);

	assign ram_we = bus.mem_wr & ~rom_space;
	assign ram_rd = bus.mem_rd;
	assign screen_page = page_reg[`ZX_PAGE_SCREEN_BIT];

endmodule

// File: ula/zx_beeper_dac.sv
// First-order sigma-delta DAC for the beeper level
`timescale 1ns/1ps
`include "zx_config.svh"

module zx_beeper_dac (
	input logic clk_sys,
	input logic reset,
	input zx_pkg::zx_level_t level,
	output logic dac_out
);

	// One extra bit holds the carry
	logic [`ZX_DAC_W:0] acc;
	logic [`ZX_DAC_W:0] acc_next;

	// Previous carry is dropped before adding
	assign acc_next = {1'b0, acc[`ZX_DAC_W-1:0]} + {1'b0, level};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

	// Carry density is level / 512
	assign dac_out = acc[`ZX_DAC_W];

endmodule

// File: ula/zx_ula_port.sv
// ULA port FE: border, EAR and MIC latches, keyboard and tape read value, beeper mix
`timescale 1ns/1ps

module zx_ula_port (
	input logic clk_sys,
	input logic reset,
	zx_bus_if.ula bus,
	input logic [4:0] key_data,
	input logic tape_in,
	output logic [2:0] border,
	output zx_pkg::zx_data_t ula_dout,
	output logic audio
);
	import zx_pkg::*;

	logic ula_we;
	logic ear_out;
	logic mic_out;
	zx_level_t beep_level;

	// Any even port
	assign ula_we = bus.io_wr_pulse & ~bus.addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			mic_out <= 1'b0;
			ear_out <= 1'b0;
		end else if (ula_we) begin
			border <= bus.cpu_dout[2:0];
			mic_out <= bus.cpu_dout[3];
			ear_out <= bus.cpu_dout[4];
		end
	end

	// Keys active low, tape bit inverted
	assign ula_dout = {1'b1, ~tape_in, 1'b1, key_data};

	// EAR 128, MIC 64, tape 32
	assign beep_level = {1'b0, ear_out, mic_out, tape_in, 5'b00000};

	zx_beeper_dac i_beeper_dac (
		.clk_sys(clk_sys),
		.reset(reset),
		.level(beep_level),
		.dac_out(audio)
	);

endmodule

// File: source/zx_read_mux.sv
// CPU read data multiplexer: RAM, ULA port or idle bus
`timescale 1ns/1ps

module zx_read_mux (
	zx_bus_if.mux bus,
	input logic ram_rd,
	input zx_pkg::zx_data_t ram_dout,
	input zx_pkg::zx_data_t ula_dout,
	output zx_pkg::zx_data_t cpu_din
);

	logic ula_rd;

	assign ula_rd = bus.io_rd & ~bus.addr[0];

	always_comb begin
		if (ram_rd) begin
			cpu_din = ram_dout;
		end else if (ula_rd) begin
			cpu_din = ula_dout;
		end else begin
			// Floating bus
			cpu_din = '1;
		end
	end

endmodule

// File: source/zx_spectrum_core.sv
// Top level with bus strobes, memory pager, ULA port and read mux
`timescale 1ns/1ps

module zx_spectrum_core (
	input logic clk_sys,
	input logic reset,
	input zx_pkg::zx_model_t model,
	input zx_pkg::zx_addr_t addr,
	input zx_pkg::zx_data_t cpu_dout,
	input logic m1_n,
	input logic mreq_n,
	input logic iorq_n,
	input logic rd_n,
	input logic wr_n,
	input logic [4:0] key_data,
	input logic tape_in,
	input zx_pkg::zx_data_t ram_dout,
	output zx_pkg::zx_data_t cpu_din,
	output zx_pkg::zx_ram_addr_t ram_addr,
	output logic ram_we,
	output logic ram_rd,
	output logic screen_page,
	output logic [2:0] border,
	output logic audio
);
	import zx_pkg::*;

	zx_data_t ula_dout;

	zx_bus_if zx_bus ();

	zx_bus_strobe i_bus_strobe (
		.clk_sys(clk_sys),
		.reset(reset),
		.addr(addr),
		.cpu_dout(cpu_dout),
		.m1_n(m1_n),
		.mreq_n(mreq_n),
		.iorq_n(iorq_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.bus(zx_bus.strobe)
	);

	zx_memory_pager i_memory_pager (
		.clk_sys(clk_sys),
		.reset(reset),
		.model(model),
		.bus(zx_bus.pager),
		.ram_addr(ram_addr),
		.ram_we(ram_we),
		.ram_rd(ram_rd),
		.screen_page(screen_page)
	);

	zx_ula_port i_ula_port (
		.clk_sys(clk_sys),
		.reset(reset),
		.bus(zx_bus.ula),
		.key_data(key_data),
		.tape_in(tape_in),
		.border(border),
		.ula_dout(ula_dout),
		.audio(audio)
	);

	zx_read_mux i_read_mux (
		.bus(zx_bus.mux),
		.ram_rd(ram_rd),
		.ram_dout(ram_dout),
		.ula_dout(ula_dout),
		.cpu_din(cpu_din)
	);

endmodule

// File: sim/tb_zx_spectrum_core.sv
// Testbench for the Spectrum core with paging table, write timing, ULA port and beeper DAC checks
`timescale 1ns/1ps

module tb_zx_spectrum_core;
	import zx_pkg::*;

	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 10;
	localparam int DAC_WINDOW = 512;
	localparam int DAC_TIMEOUT = 1024;
	localparam int MAX_CASES = 16;

	// Bus cycle kinds
	localparam int CYC_OUT = 0;
	localparam int CYC_IN = 1;
	localparam int CYC_MEM_RD = 2;
	localparam int CYC_MEM_WR = 3;

	logic clk_sys = 1'b0;
	logic reset;
	zx_model_t model;
	zx_addr_t addr;
	zx_data_t cpu_dout;
	logic m1_n;
	logic mreq_n;
	logic iorq_n;
	logic rd_n;
	logic wr_n;
	logic [4:0] key_data;
	logic tape_in;
	zx_data_t ram_dout;
	zx_data_t cpu_din;
	zx_ram_addr_t ram_addr;
	logic ram_we;
	logic ram_rd;
	logic screen_page;
	logic [2:0] border;
	logic audio;

	int value_errors = 0;
	int timeout_errors = 0;
	logic [15:0] lfsr_state;

	// Paging table
	// Map nibbles run from quarter 0 in the top nibble down to quarter 3
	// Bit 3 of a nibble marks ROM space
	zx_model_t tbl_model [MAX_CASES];
	int tbl_nwr [MAX_CASES];
	zx_addr_t tbl_wr_addr [MAX_CASES][2];
	zx_data_t tbl_wr_data [MAX_CASES][2];
	logic [15:0] tbl_map [MAX_CASES];
	logic tbl_screen [MAX_CASES];
	logic [13:0] tbl_offset [MAX_CASES];
	int n_cases = 0;

	zx_spectrum_core i_zx_spectrum_core (
		.clk_sys(clk_sys),
		.reset(reset),
		.model(model),
		.addr(addr),
		.cpu_dout(cpu_dout),
		.m1_n(m1_n),
		.mreq_n(mreq_n),
		.iorq_n(iorq_n),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.key_data(key_data),
		.tape_in(tape_in),
		.ram_dout(ram_dout),
		.cpu_din(cpu_din),
		.ram_addr(ram_addr),
		.ram_we(ram_we),
		.ram_rd(ram_rd),
		.screen_page(screen_page),
		.border(border),
		.audio(audio)
	);

	always begin
		#(CLK_HALF) clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_ram_addr(input string name, input zx_ram_addr_t act,
			input zx_ram_addr_t exp);
		if (act !== exp) begin
			$display("ERROR %s actual 0x%05h expected 0x%05h", name, act, exp);
			value_errors++;
		end
	endtask

	task automatic check_data(input string name, input zx_data_t act, input zx_data_t exp);
		if (act !== exp) begin
			$display("ERROR %s actual 0x%02h expected 0x%02h", name, act, exp);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("ERROR %s actual 0x%01h expected 0x%01h", name, act, exp);
			value_errors++;
		end
	endtask

	// Ones in a DAC window may be one off either way
	task automatic check_density(input string name, input int count, input int level);
		if (count < level - 1 || count > level + 1) begin
			$display("ERROR %s ones 0x%03h expected 0x%03h", name, count, level);
			value_errors++;
		end
	endtask

	// ======================================================================
	// Stimulus helpers
	// ======================================================================

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] take_bits(input int n);
		logic fb;
		logic [15:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	task automatic set_idle();
		m1_n = 1'b1;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic apply_reset(input zx_model_t m);
		int i;
		@(negedge clk_sys);
		model = m;
		reset = 1'b1;
		set_idle();
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk_sys);
		end
		reset = 1'b0;
	endtask

	// One CPU cycle with outputs sampled at the falling edge that ends it
	task automatic bus_cycle(input int kind, input zx_addr_t a, input zx_data_t d,
			output zx_data_t din, output zx_ram_addr_t raddr, output logic we,
			output logic rd);
		logic [15:0] rnd;
		@(negedge clk_sys);
		rnd = take_bits(8);
		addr = a;
		cpu_dout = d;
		ram_dout = rnd[7:0];
		m1_n = 1'b1;
		mreq_n = !(kind == CYC_MEM_RD || kind == CYC_MEM_WR);
		iorq_n = !(kind == CYC_IN || kind == CYC_OUT);
		rd_n = !(kind == CYC_IN || kind == CYC_MEM_RD);
		wr_n = !(kind == CYC_OUT || kind == CYC_MEM_WR);
		@(negedge clk_sys);
		din = cpu_din;
		raddr = ram_addr;
		we = ram_we;
		rd = ram_rd;
		set_idle();
	endtask

	task automatic add_case(input zx_model_t m, input int nwr, input zx_addr_t a0,
			input zx_data_t d0, input zx_addr_t a1, input zx_data_t d1,
			input logic [15:0] map, input logic scr, input logic [13:0] off);
		tbl_model[n_cases] = m;
		tbl_nwr[n_cases] = nwr;
		tbl_wr_addr[n_cases][0] = a0;
		tbl_wr_data[n_cases][0] = d0;
		tbl_wr_addr[n_cases][1] = a1;
		tbl_wr_data[n_cases][1] = d1;
		tbl_map[n_cases] = map;
		tbl_screen[n_cases] = scr;
		tbl_offset[n_cases] = off;
		n_cases++;
	endtask

	task automatic build_table();
		add_case(MODEL_128, 0, 16'h0000, 8'h00, 16'h0000, 8'h00, 16'h8520, 1'b0, 14'h0123);
		add_case(MODEL_128, 1, 16'h7FFD, 8'h1B, 16'h0000, 8'h00, 16'h9523, 1'b1, 14'h3FFF);
		// Second write is ignored once the lock bit is set
		add_case(MODEL_128, 2, 16'h7FFD, 8'h27, 16'h7FFD, 8'h18, 16'h8527, 1'b0, 14'h2A55);
		add_case(MODEL_128, 1, 16'h3FFD, 8'h1E, 16'h0000, 8'h00, 16'h9526, 1'b1, 14'h0000);
		add_case(MODEL_48, 1, 16'h7FFD, 8'h1F, 16'h0000, 8'h00, 16'h9520, 1'b0, 14'h1234);
		// +3 all-RAM sets
		add_case(MODEL_PLUS3, 1, 16'h1FFD, 8'h01, 16'h0000, 8'h00, 16'h0123, 1'b0, 14'h0F0F);
		add_case(MODEL_PLUS3, 1, 16'h1FFD, 8'h03, 16'h0000, 8'h00, 16'h4567, 1'b0, 14'h3A5C);
		add_case(MODEL_PLUS3, 1, 16'h1FFD, 8'h05, 16'h0000, 8'h00, 16'h4563, 1'b0, 14'h0001);
		add_case(MODEL_PLUS3, 1, 16'h1FFD, 8'h07, 16'h0000, 8'h00, 16'h4763, 1'b0, 14'h2000);
		// +3 ROM numbers
		add_case(MODEL_PLUS3, 1, 16'h7FFD, 8'h10, 16'h0000, 8'h00, 16'h9520, 1'b0, 14'h2B2B);
		add_case(MODEL_PLUS3, 1, 16'h1FFD, 8'h04, 16'h0000, 8'h00, 16'hA520, 1'b0, 14'h1FFE);
		add_case(MODEL_PLUS3, 2, 16'h7FFD, 8'h12, 16'h1FFD, 8'h04, 16'hB522, 1'b0, 14'h0456);
		add_case(MODEL_PLUS3, 1, 16'h3FFD, 8'h1F, 16'h0000, 8'h00, 16'h8520, 1'b0, 14'h3333);
		add_case(MODEL_PLUS3, 2, 16'h7FFD, 8'h08, 16'h1FFD, 8'h01, 16'h0123, 1'b1, 14'h1111);
	endtask

	// ======================================================================
	// Test steps
	// ======================================================================

	task automatic run_case(input int c);
		zx_data_t din;
		zx_ram_addr_t raddr;
		zx_ram_addr_t exp_addr;
		zx_addr_t a;
		logic we;
		logic rd;
		logic [3:0] code;
		logic [15:0] rnd;
		int i;
		int q;
		apply_reset(tbl_model[c]);
		check_bit("ram_we", ram_we, 1'b0);
		check_bit("ram_rd", ram_rd, 1'b0);
		for (i = 0; i < tbl_nwr[c]; i++) begin
			bus_cycle(CYC_OUT, tbl_wr_addr[c][i], tbl_wr_data[c][i], din, raddr, we, rd);
		end
		check_bit("screen_page", screen_page, tbl_screen[c]);
		for (q = 0; q < 4; q++) begin
			a = {q[1:0], tbl_offset[c]};
			code = tbl_map[c][(3 - q) * 4 +: 4];
			if (code[3]) begin
				exp_addr = {2'b10, code[1:0], a[13:0]};
			end else begin
				exp_addr = {1'b0, code[2:0], a[13:0]};
			end
			bus_cycle(CYC_MEM_RD, a, 8'h00, din, raddr, we, rd);
			check_ram_addr("ram_addr", raddr, exp_addr);
			check_data("cpu_din", din, ram_dout);
			check_bit("ram_rd", rd, 1'b1);
			check_bit("ram_we", we, 1'b0);
			rnd = take_bits(8);
			bus_cycle(CYC_MEM_WR, a, rnd[7:0], din, raddr, we, rd);
			check_ram_addr("ram_addr", raddr, exp_addr);
			check_bit("ram_we", we, !code[3]);
			check_bit("ram_rd", rd, 1'b0);
		end
	endtask

	// Register loads once per OUT at its first rising edge
	task automatic check_write_timing();
		apply_reset(MODEL_128);
		@(negedge clk_sys);
		addr = 16'h7FFD;
		cpu_dout = 8'h08;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		#(CLK_HALF / 2);
		check_bit("screen_page", screen_page, 1'b0);
		@(negedge clk_sys);
		check_bit("screen_page", screen_page, 1'b1);
		cpu_dout = 8'h00;
		@(negedge clk_sys);
		check_bit("screen_page", screen_page, 1'b1);
		set_idle();
	endtask

	task automatic check_ula();
		zx_data_t din;
		zx_data_t exp_din;
		zx_ram_addr_t raddr;
		logic we;
		logic rd;
		logic [15:0] rnd;
		int i;
		apply_reset(MODEL_128);
		check_data("border", {5'b00000, border}, 8'h00);
		bus_cycle(CYC_OUT, 16'h00FE, 8'h05, din, raddr, we, rd);
		check_data("border", {5'b00000, border}, 8'h05);
		for (i = 0; i < 4; i++) begin
			rnd = take_bits(5);
			key_data = rnd[4:0];
			rnd = take_bits(1);
			tape_in = rnd[0];
			bus_cycle(CYC_IN, 16'hFEFE, 8'h00, din, raddr, we, rd);
			// Bits 7 and 5 read one, bit 6 is set while the tape level is low
			exp_din = 8'hA0 | {3'b000, key_data};
			if (!tape_in) begin
				exp_din[6] = 1'b1;
			end
			check_data("cpu_din", din, exp_din);
		end
		// Keys and tape chosen so that the ULA value differs from FF
		key_data = 5'h00;
		tape_in = 1'b1;
		bus_cycle(CYC_IN, 16'h00FF, 8'h00, din, raddr, we, rd);
		check_data("cpu_din", din, 8'hFF);
	endtask

	task automatic check_beeper(input logic ear, input logic mic, input logic tape);
		zx_data_t din;
		zx_ram_addr_t raddr;
		logic we;
		logic rd;
		int level;
		int waited;
		int ones;
		int i;
		bus_cycle(CYC_OUT, 16'h00FE, {3'b000, ear, mic, 3'b010}, din, raddr, we, rd);
		tape_in = tape;
		level = 128 * ear + 64 * mic + 32 * tape;
		waited = 0;
		while (audio !== 1'b1 && waited < DAC_TIMEOUT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (audio !== 1'b1) begin
			$display("Timeout: audio never went high for beeper level %0d", level);
			timeout_errors++;
		end else begin
			ones = 0;
			for (i = 0; i < DAC_WINDOW; i++) begin
				@(negedge clk_sys);
				ones += audio;
			end
			check_density("audio", ones, level);
		end
	endtask

	initial begin
		int c;
		reset = 1'b1;
		model = MODEL_128;
		addr = '0;
		cpu_dout = '0;
		set_idle();
		key_data = 5'h1F;
		tape_in = 1'b0;
		ram_dout = '0;
		lfsr_state = 16'd41270;
		build_table();
		for (c = 0; c < n_cases; c++) begin
			run_case(c);
		end
		check_write_timing();
		check_ula();
		check_beeper(1'b1, 1'b1, 1'b1);
		check_beeper(1'b1, 1'b0, 1'b0);
		check_beeper(1'b0, 1'b1, 1'b0);
		check_beeper(1'b0, 1'b0, 1'b1);
		$display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/zx_pkg.sv
common/zx_bus_if.sv
source/zx_bus_strobe.sv
memory_pager/zx_memory_pager.sv
ula/zx_beeper_dac.sv
ula/zx_ula_port.sv
source/zx_read_mux.sv
source/zx_spectrum_core.sv
sim/tb_zx_spectrum_core.sv

// File: Bender.yml
package:
  name: zx_spectrum_core

sources:
  - include_dirs:
      - common
    files:
      - common/zx_pkg.sv
      - common/zx_bus_if.sv
      - source/zx_bus_strobe.sv
      - memory_pager/zx_memory_pager.sv
      - ula/zx_beeper_dac.sv
      - ula/zx_ula_port.sv
      - source/zx_read_mux.sv
      - source/zx_spectrum_core.sv

  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_zx_spectrum_core.sv
